/* src.f */
+incdir+.
guard_pkg.sv
guard_bus_if.sv
guard_regs.sv
guard_ingress.sv
guard_monitor.sv
guard_egress.sv
slv_guard_top.sv
tb_sub_model.sv
tb_slv_guard.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_slv_guard -o vtb
	-./obj_dir/vtb 2>&1 | tee sim.log
	@! grep -q "test failed" sim.log
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_slv_guard.sv */
// Subordinate guard testbench

`default_nettype none

`include "guard_params.svh"

module tb_slv_guard;

  timeunit 1ns;
  timeprecision 100ps;

  // Transactions over all phases, sizes the watchdog
  localparam int N_TXNS = 77;

  logic clk_i, reset_i, guard_ena_i;
  logic mgr_req_valid_i, mgr_req_ready_o, mgr_req_we_i;
  logic [`GUARD_ADDR_W-1:0] mgr_req_addr_i, sub_req_addr_o;
  logic [`GUARD_DATA_W-1:0] mgr_req_wdata_i, mgr_rsp_rdata_o;
  logic [`GUARD_ID_W-1:0]   mgr_req_id_i, mgr_rsp_id_o;
  logic mgr_rsp_valid_o, mgr_rsp_ready_i, mgr_rsp_err_o;
  logic sub_req_valid_o, sub_req_ready_i, sub_req_we_o;
  logic [`GUARD_DATA_W-1:0] sub_req_wdata_o, sub_rsp_rdata_i;
  logic [`GUARD_ID_W-1:0]   sub_req_id_o, sub_rsp_id_i;
  logic sub_rsp_valid_i, sub_rsp_ready_o, sub_rsp_err_i;
  logic reg_valid_i, reg_write_i;
  logic [1:0] reg_addr_i;
  logic [`GUARD_DATA_W-1:0] reg_wdata_i, reg_rdata_o;
  logic irq_o, rst_req_o, rst_stat_i;
  logic [31:0] req_stall, rsp_stall, rd_val, lcg_state;
  // Manager ready held low, ready gaps on, expected error responses on
  logic rdy_hold, rdy_gaps, err_mode;
  // Manager ready picked at the clock edge
  logic rdy_next;
  logic [`GUARD_DATA_W-1:0] model_mem [256];
  logic [`GUARD_ID_W-1:0]   exp_id_q [$];
  logic [`GUARD_DATA_W-1:0] exp_data_q [$];
  logic                     exp_err_q [$];

  slv_guard_top i_slv_guard_top (.*);

  tb_sub_model i_sub (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_valid_i(sub_req_valid_o), .req_ready_o(sub_req_ready_i),
    .req_addr_i(sub_req_addr_o), .req_we_i(sub_req_we_o),
    .req_wdata_i(sub_req_wdata_o), .req_id_i(sub_req_id_o),
    .rsp_valid_o(sub_rsp_valid_i), .rsp_ready_i(sub_rsp_ready_o),
    .rsp_id_o(sub_rsp_id_i), .rsp_rdata_o(sub_rsp_rdata_i), .rsp_err_o(sub_rsp_err_i),
    .req_stall_i(req_stall), .rsp_stall_i(rsp_stall),
    .rst_req_i(rst_req_o), .rst_stat_o(rst_stat_i)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
    @(posedge clk_i) #1;
    reg_valid_i = 1'b1;
    reg_write_i = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(posedge clk_i) #1;
    reg_valid_i = 1'b0;
  endtask

  task automatic reg_read(input logic [1:0] addr, output logic [31:0] data);
    @(posedge clk_i) #1;
    reg_valid_i = 1'b1;
    reg_write_i = 1'b0;
    reg_addr_i  = addr;
    @(posedge clk_i) #1;
    reg_valid_i = 1'b0;
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  // One random request, held until the guard accepts it
  task automatic issue_random();
    @(posedge clk_i) #1;
    mgr_req_valid_i = 1'b1;
    mgr_req_we_i    = next_rand() % 2;
    mgr_req_addr_i  = `GUARD_ADDR_W'(next_rand() % 16);
    mgr_req_wdata_i = next_rand();
    mgr_req_id_i    = `GUARD_ID_W'(next_rand());
    do @(negedge clk_i); while (!mgr_req_ready_o);
    @(posedge clk_i) #1;
    mgr_req_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_id_q.size() != 0) @(posedge clk_i);
    @(posedge clk_i);
    @(posedge clk_i) #1;
  endtask

  // Manager ready, held low or with random gaps
  always @(posedge clk_i) begin
    rdy_next = rdy_hold ? 1'b0 : (rdy_gaps ? (next_rand() % 3 != 0) : 1'b1);
    #1 mgr_rsp_ready_i = rdy_next;
  end

  // Reference model, sampled mid-cycle where all signals are stable
  always @(negedge clk_i) begin
    if (!reset_i && mgr_req_valid_i && mgr_req_ready_o) begin
      exp_id_q.push_back(mgr_req_id_i);
      exp_err_q.push_back(err_mode);
      exp_data_q.push_back((err_mode || mgr_req_we_i) ? '0 : model_mem[mgr_req_addr_i[7:0]]);
      if (mgr_req_we_i) begin
        model_mem[mgr_req_addr_i[7:0]] = mgr_req_wdata_i;
      end
    end
    if (!reset_i && mgr_rsp_valid_o && mgr_rsp_ready_i) begin
      assert (exp_id_q.size() != 0) else begin
        $display("** Error at %0t ns: response reached the manager with none expected", $time);
        $display("test failed");
        $fatal(1);
      end
      check_val("mgr_rsp_id_o", mgr_rsp_id_o, exp_id_q.pop_front());
      check_val("mgr_rsp_err_o", mgr_rsp_err_o, exp_err_q.pop_front());
      check_val("mgr_rsp_rdata_o", mgr_rsp_rdata_o, exp_data_q.pop_front());
    end
  end

  initial begin
    #(N_TXNS * 200 * 4);
    $display("** Error at %0t ns: watchdog expired before the tests finished", $time);
    $display("test failed");
    $fatal(1);
  end

  initial begin
    lcg_state = 32'd84570;
    for (int i = 0; i < 256; i++) begin
      model_mem[i] = {16'hc0de, ~8'(i), 8'(i)};
    end
    clk_i = 1'b0;
    reset_i = 1'b1;
    guard_ena_i = 1'b1;
    mgr_req_valid_i = 1'b0;
    mgr_req_addr_i = '0;
    mgr_req_we_i = 1'b0;
    mgr_req_wdata_i = '0;
    mgr_req_id_i = '0;
    mgr_rsp_ready_i = 1'b1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    req_stall = 0;
    rsp_stall = 0;
    rdy_hold = 1'b0;
    rdy_gaps = 1'b0;
    err_mode = 1'b0;
    repeat (16) @(posedge clk_i);
    #1 reset_i = 1'b0;

    // Outputs quiet after reset
    check_val("irq_o", irq_o, 0);
    check_val("rst_req_o", rst_req_o, 0);
    check_val("mgr_rsp_valid_o", mgr_rsp_valid_o, 0);

    // Register readback and reset values
    reg_read(2'd0, rd_val);
    check_val("REQ_BUDGET", rd_val, 255);
    reg_read(2'd1, rd_val);
    check_val("RSP_BUDGET", rd_val, 255);
    reg_read(2'd2, rd_val);
    check_val("IRQ_STATUS", rd_val, 0);
    reg_read(2'd3, rd_val);
    check_val("FAULT_COUNT", rd_val, 0);
    reg_write(2'd0, 200);
    reg_read(2'd0, rd_val);
    check_val("REQ_BUDGET", rd_val, 200);
    reg_write(2'd1, 150);
    reg_read(2'd1, rd_val);
    check_val("RSP_BUDGET", rd_val, 150);
    reg_write(2'd0, 255);
    reg_write(2'd1, 255);

    // Random traffic under generous budgets
    repeat (40) begin
      req_stall = next_rand() % 21;
      rsp_stall = next_rand() % 21;
      issue_random();
    end
    wait_drained();
    check_val("irq_o", irq_o, 0);

    // Request never accepted, untracked so no error response
    reg_write(2'd0, 5);
    req_stall = 1000000;
    rsp_stall = 0;
    fork
      issue_random();
      begin
        wait (irq_o);
        wait (rst_req_o);
        #1 req_stall = 0;
      end
    join
    wait_drained();
    reg_read(2'd3, rd_val);
    check_val("FAULT_COUNT", rd_val, 1);
    reg_write(2'd0, 255);

    // Sticky irq until written with one
    check_val("irq_o", irq_o, 1);
    reg_write(2'd2, 1);
    check_val("irq_o", irq_o, 0);

    // Withheld responses, drained with errors in order
    reg_write(2'd1, 10);
    rsp_stall = 100;
    err_mode = 1'b1;
    rdy_hold = 1'b1;
    repeat (3) issue_random();
    // Drain stalls until the late subordinate response is swallowed
    wait (sub_rsp_valid_i && sub_rsp_ready_o);
    @(posedge clk_i) #1;
    rdy_hold = 1'b0;
    wait_drained();
    wait (rst_req_o);
    wait (!rst_req_o);
    @(posedge clk_i) #1;
    err_mode = 1'b0;
    rsp_stall = 0;
    repeat (4) @(posedge clk_i);
    check_val("irq_o", irq_o, 1);
    reg_write(2'd2, 1);
    check_val("irq_o", irq_o, 0);

    // Manager back-pressure never counts against the budget
    reg_write(2'd0, 10);
    rdy_gaps = 1'b1;
    repeat (30) begin
      req_stall = next_rand() % 4;
      rsp_stall = next_rand() % 4;
      issue_random();
    end
    wait_drained();
    rdy_gaps = 1'b0;
    check_val("irq_o", irq_o, 0);

    // Guard disabled, long stalls pass untouched
    guard_ena_i = 1'b0;
    req_stall = 0;
    rsp_stall = 100;
    repeat (3) issue_random();
    wait_drained();
    check_val("irq_o", irq_o, 0);
    check_val("rst_req_o", rst_req_o, 0);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_sub_model.sv */
// Testbench subordinate model

`default_nettype none

`include "guard_params.svh"

module tb_sub_model (
  input  wire                       clk_i,
  input  wire                       reset_i,
  input  wire                       req_valid_i,
  output logic                      req_ready_o,
  input  wire [`GUARD_ADDR_W-1:0]   req_addr_i,
  input  wire                       req_we_i,
  input  wire [`GUARD_DATA_W-1:0]   req_wdata_i,
  input  wire [`GUARD_ID_W-1:0]     req_id_i,
  output logic                      rsp_valid_o,
  input  wire                       rsp_ready_i,
  output logic [`GUARD_ID_W-1:0]    rsp_id_o,
  output logic [`GUARD_DATA_W-1:0]  rsp_rdata_o,
  output logic                      rsp_err_o,
  // Cycles to wait before accepting and before responding
  input  wire [31:0]                req_stall_i,
  input  wire [31:0]                rsp_stall_i,
  input  wire                       rst_req_i,
  output logic                      rst_stat_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [`GUARD_DATA_W-1:0] mem [256];
  logic [`GUARD_ID_W-1:0]   fifo_id [16];
  logic [`GUARD_DATA_W-1:0] fifo_data [16];
  logic [3:0]               wr_ptr;
  logic [3:0]               rd_ptr;
  logic [4:0]               count;
  logic [31:0]              req_cnt;
  logic [31:0]              rsp_cnt;
  logic                     accept;
  logic                     give;

  initial begin
    // Quiet outputs before the first clock edge
    rst_stat_o = 1'b0;
    req_cnt    = 0;
    rsp_cnt    = 0;
    count      = '0;
    // Fill pattern built from the whole address
    for (int i = 0; i < 256; i++) begin
      mem[i] = {16'hc0de, ~8'(i), 8'(i)};
    end
  end

  assign req_ready_o = (req_cnt >= req_stall_i);
  assign rsp_valid_o = (count != 0) && (rsp_cnt >= rsp_stall_i);
  assign rsp_id_o    = fifo_id[rd_ptr];
  assign rsp_rdata_o = fifo_data[rd_ptr];
  assign rsp_err_o   = 1'b0;
  assign accept      = req_valid_i & req_ready_o;
  assign give        = rsp_valid_o & rsp_ready_i;

  always @(posedge clk_i) begin
    // Reset request flushes all pending responses
    rst_stat_o <= !reset_i && rst_req_i;
    if (reset_i || rst_req_i) begin
      req_cnt <= 0;
      rsp_cnt <= 0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
    end else begin
      req_cnt <= (req_valid_i && !req_ready_o) ? req_cnt + 1 : 0;
      if (accept) begin
        if (req_we_i) begin
          mem[req_addr_i[7:0]] <= req_wdata_i;
        end
        fifo_id[wr_ptr]   <= req_id_i;
        fifo_data[wr_ptr] <= req_we_i ? '0 : mem[req_addr_i[7:0]];
        wr_ptr            <= wr_ptr + 1'b1;
      end
      if (give) begin
        rd_ptr  <= rd_ptr + 1'b1;
        rsp_cnt <= 0;
      end else if (count != 0 && !rsp_valid_o) begin
        rsp_cnt <= rsp_cnt + 1;
      end
      count <= count + 5'(accept) - 5'(give);
    end
  end

endmodule

`default_nettype wire

/* slv_guard_top.sv */
// Subordinate latency guard

`default_nettype none

`include "guard_params.svh"

module slv_guard_top (
  input  wire                       clk_i,
  input  wire                       reset_i,
  input  wire                       guard_ena_i,
  // Manager request
  input  wire                       mgr_req_valid_i,
  output logic                      mgr_req_ready_o,
  input  wire [`GUARD_ADDR_W-1:0]   mgr_req_addr_i,
  input  wire                       mgr_req_we_i,
  input  wire [`GUARD_DATA_W-1:0]   mgr_req_wdata_i,
  input  wire [`GUARD_ID_W-1:0]     mgr_req_id_i,
  // Manager response
  output logic                      mgr_rsp_valid_o,
  input  wire                       mgr_rsp_ready_i,
  output logic [`GUARD_ID_W-1:0]    mgr_rsp_id_o,
  output logic [`GUARD_DATA_W-1:0]  mgr_rsp_rdata_o,
  output logic                      mgr_rsp_err_o,
  // Subordinate request
  output logic                      sub_req_valid_o,
  input  wire                       sub_req_ready_i,
  output logic [`GUARD_ADDR_W-1:0]  sub_req_addr_o,
  output logic                      sub_req_we_o,
  output logic [`GUARD_DATA_W-1:0]  sub_req_wdata_o,
  output logic [`GUARD_ID_W-1:0]    sub_req_id_o,
  // Subordinate response
  input  wire                       sub_rsp_valid_i,
  output logic                      sub_rsp_ready_o,
  input  wire [`GUARD_ID_W-1:0]     sub_rsp_id_i,
  input  wire [`GUARD_DATA_W-1:0]   sub_rsp_rdata_i,
  input  wire                       sub_rsp_err_i,
  // Configuration register port
  input  wire                       reg_valid_i,
  input  wire                       reg_write_i,
  input  wire [1:0]                 reg_addr_i,
  input  wire [`GUARD_DATA_W-1:0]   reg_wdata_i,
  output logic [`GUARD_DATA_W-1:0]  reg_rdata_o,
  // Interrupt and subordinate reset handshake
  output logic                      irq_o,
  output logic                      rst_req_o,
  input  wire                       rst_stat_i
);

  import guard_pkg::*;

  guard_bus_if sub_bus ();

  guard_reg_e              reg_addr;
  guard_state_e            state;
  track_entry_t            head;
  logic                    fault;
  logic                    pop;
  logic                    track_empty;
  logic                    rsp_stall;
  logic [`GUARD_CNT_W-1:0] req_budget;
  logic [`GUARD_CNT_W-1:0] rsp_budget;

  assign reg_addr = guard_reg_e'(reg_addr_i);

  // Subordinate ports onto the bundle
  assign sub_req_valid_o     = sub_bus.req_valid;
  assign sub_req_addr_o      = sub_bus.req_addr;
  assign sub_req_we_o        = sub_bus.req_we;
  assign sub_req_wdata_o     = sub_bus.req_wdata;
  assign sub_req_id_o        = sub_bus.req_id;
  assign sub_bus.req_ready   = sub_req_ready_i;
  assign sub_bus.rsp_valid   = sub_rsp_valid_i;
  assign sub_bus.rsp_id      = sub_rsp_id_i;
  assign sub_bus.rsp_rdata   = sub_rsp_rdata_i;
  assign sub_bus.rsp_err     = sub_rsp_err_i;
  assign sub_rsp_ready_o     = sub_bus.rsp_ready;

  guard_regs i_regs (
    .clk_i        ( clk_i       ),
    .reset_i      ( reset_i     ),
    .reg_valid_i  ( reg_valid_i ),
    .reg_write_i  ( reg_write_i ),
    .reg_addr_i   ( reg_addr    ),
    .reg_wdata_i  ( reg_wdata_i ),
    .reg_rdata_o  ( reg_rdata_o ),
    .fault_i      ( fault       ),
    .req_budget_o ( req_budget  ),
    .rsp_budget_o ( rsp_budget  ),
    .irq_o        ( irq_o       )
  );

  guard_ingress i_ingress (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .mgr_req_valid_i ( mgr_req_valid_i ),
    .mgr_req_ready_o ( mgr_req_ready_o ),
    .mgr_req_addr_i  ( mgr_req_addr_i  ),
    .mgr_req_we_i    ( mgr_req_we_i    ),
    .mgr_req_wdata_i ( mgr_req_wdata_i ),
    .mgr_req_id_i    ( mgr_req_id_i    ),
    .sub             ( sub_bus.mgr     ),
    .pass_i          ( state           ),
    .pop_i           ( pop             ),
    .head_o          ( head            ),
    .track_empty_o   ( track_empty     )
  );

  guard_monitor i_monitor (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .guard_ena_i   ( guard_ena_i ),
    .sub           ( sub_bus.mgr ),
    .rsp_stall_i   ( rsp_stall   ),
    .track_empty_i ( track_empty ),
    .pop_i         ( pop         ),
    .req_budget_i  ( req_budget  ),
    .rsp_budget_i  ( rsp_budget  ),
    .rst_stat_i    ( rst_stat_i  ),
    .state_o       ( state       ),
    .fault_o       ( fault       ),
    .rst_req_o     ( rst_req_o   )
  );

  guard_egress i_egress (
    .state_i         ( state           ),
    .sub             ( sub_bus.mgr     ),
    .head_i          ( head            ),
    .track_empty_i   ( track_empty     ),
    .mgr_rsp_valid_o ( mgr_rsp_valid_o ),
    .mgr_rsp_ready_i ( mgr_rsp_ready_i ),
    .mgr_rsp_id_o    ( mgr_rsp_id_o    ),
    .mgr_rsp_rdata_o ( mgr_rsp_rdata_o ),
    .mgr_rsp_err_o   ( mgr_rsp_err_o   ),
    .pop_o           ( pop             ),
    .rsp_stall_o     ( rsp_stall       )
  );

endmodule

`default_nettype wire

/* guard_egress.sv */
// Response path and error responder

`default_nettype none

`include "guard_params.svh"

module guard_egress (
  input  wire guard_pkg::guard_state_e  state_i,
  // Subordinate side bundle
  guard_bus_if.mgr                      sub,
  // Oldest tracked transaction
  input  wire guard_pkg::track_entry_t  head_i,
  input  wire                           track_empty_i,
  // Manager response channel
  output logic                          mgr_rsp_valid_o,
  input  wire                           mgr_rsp_ready_i,
  output logic [`GUARD_ID_W-1:0]        mgr_rsp_id_o,
  output logic [`GUARD_DATA_W-1:0]      mgr_rsp_rdata_o,
  output logic                          mgr_rsp_err_o,
  output logic                          pop_o,
  output logic                          rsp_stall_o
);

  import guard_pkg::*;

  always_comb begin
    case (state_i)
      IDLE: begin
        // Plain forwarding, manager ready back-pressures the subordinate
        mgr_rsp_valid_o = sub.rsp_valid;
        mgr_rsp_id_o    = sub.rsp_id;
        mgr_rsp_rdata_o = sub.rsp_rdata;
        mgr_rsp_err_o   = sub.rsp_err;
        sub.rsp_ready   = mgr_rsp_ready_i;
      end
      FAULT_DRAIN: begin
        // Error response for the head entry, subordinate responses dropped
        mgr_rsp_valid_o = ~track_empty_i;
        mgr_rsp_id_o    = head_i.id;
        mgr_rsp_rdata_o = '0;
        mgr_rsp_err_o   = 1'b1;
        sub.rsp_ready   = 1'b1;
      end
      default: begin
        // Late subordinate responses swallowed until reset completes
        mgr_rsp_valid_o = 1'b0;
        mgr_rsp_id_o    = '0;
        mgr_rsp_rdata_o = '0;
        mgr_rsp_err_o   = 1'b0;
        sub.rsp_ready   = 1'b1;
      end
    endcase
  end

  // Every transfer to the manager retires one tracker entry
  assign pop_o = mgr_rsp_valid_o & mgr_rsp_ready_i;

  // Manager holding a valid response
  assign rsp_stall_o = mgr_rsp_valid_o & ~mgr_rsp_ready_i;

endmodule

`default_nettype wire

/* guard_monitor.sv */
// Latency budget counters and guard FSM

`default_nettype none

`include "guard_params.svh"

module guard_monitor (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire                        guard_ena_i,
  // Subordinate bundle, only observed here
  guard_bus_if.mgr                   sub,
  // Response held by the manager
  input  wire                        rsp_stall_i,
  input  wire                        track_empty_i,
  input  wire                        pop_i,
  input  wire [`GUARD_CNT_W-1:0]     req_budget_i,
  input  wire [`GUARD_CNT_W-1:0]     rsp_budget_i,
  // Subordinate reports its reset done
  input  wire                        rst_stat_i,
  output guard_pkg::guard_state_e    state_o,
  output logic                       fault_o,
  output logic                       rst_req_o
);

  import guard_pkg::*;

  guard_state_e            state_q;
  guard_state_e            state_d;
  logic [`GUARD_CNT_W-1:0] req_wait_q;
  logic [`GUARD_CNT_W-1:0] rsp_age_q;
  logic                    req_stall;
  logic                    overrun;

  // Subordinate keeps a valid request waiting
  assign req_stall = sub.req_valid & ~sub.req_ready;

  // Request wait, cleared on acceptance or when no request waits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_wait_q <= '0;
    end else if ((state_q != IDLE) || !req_stall) begin
      req_wait_q <= '0;
    end else if (req_wait_q != '1) begin
      req_wait_q <= req_wait_q + 1'b1;
    end
  end

  // Age of the oldest outstanding transaction
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_age_q <= '0;
    end else if ((state_q != IDLE) || pop_i || track_empty_i) begin
      rsp_age_q <= '0;
    end else if (rsp_stall_i) begin
      // Manager back-pressure is not the subordinate's fault
      rsp_age_q <= rsp_age_q;
    end else if (rsp_age_q != '1) begin
      rsp_age_q <= rsp_age_q + 1'b1;
    end
  end

  // Budgets only checked while enabled and passing traffic
  assign overrun = guard_ena_i && (state_q == IDLE) &&
                   ((req_wait_q > req_budget_i) || (rsp_age_q > rsp_budget_i));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (overrun) begin
          state_d = FAULT_DRAIN;
        end
      end
      FAULT_DRAIN: begin
        // Egress has answered every tracked ID
        if (track_empty_i) begin
          state_d = RESET_WAIT;
        end
      end
      RESET_WAIT: begin
        if (rst_stat_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;
  // High in the last IDLE cycle before the drain
  assign fault_o   = overrun;
  assign rst_req_o = (state_q == RESET_WAIT);

endmodule

`default_nettype wire

/* guard_ingress.sv */
// Request gate and in-flight tracker

`default_nettype none

`include "guard_params.svh"

module guard_ingress (
  input  wire                           clk_i,
  input  wire                           reset_i,
  // Manager request channel
  input  wire                           mgr_req_valid_i,
  output logic                          mgr_req_ready_o,
  input  wire [`GUARD_ADDR_W-1:0]       mgr_req_addr_i,
  input  wire                           mgr_req_we_i,
  input  wire [`GUARD_DATA_W-1:0]       mgr_req_wdata_i,
  input  wire [`GUARD_ID_W-1:0]         mgr_req_id_i,
  // Subordinate side bundle
  guard_bus_if.mgr                      sub,
  // Guard state, requests pass only in IDLE
  input  wire guard_pkg::guard_state_e  pass_i,
  // Pop from egress on each answered transaction
  input  wire                           pop_i,
  output guard_pkg::track_entry_t       head_o,
  output logic                          track_empty_o
);

  import guard_pkg::*;

  localparam int PTR_W = $clog2(`GUARD_MAX_TXNS);
  localparam logic [PTR_W:0]   DEPTH    = (PTR_W + 1)'(`GUARD_MAX_TXNS);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`GUARD_MAX_TXNS - 1);

  // Tracker storage, no reset needed
  track_entry_t     track_mem [`GUARD_MAX_TXNS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  // Occupancy, one bit wider than the pointers
  logic [PTR_W:0]   count_q;
  logic             pass;
  logic             full;
  logic             push;
  logic             pop;

  assign pass = (pass_i == IDLE);
  assign full = (count_q == DEPTH);

  // Valid and ready both blocked when full or not in IDLE
  assign sub.req_valid   = mgr_req_valid_i & pass & ~full;
  assign mgr_req_ready_o = sub.req_ready & pass & ~full;

  // Payload goes straight through
  assign sub.req_addr  = mgr_req_addr_i;
  assign sub.req_we    = mgr_req_we_i;
  assign sub.req_wdata = mgr_req_wdata_i;
  assign sub.req_id    = mgr_req_id_i;

  assign push = sub.req_valid & sub.req_ready;
  // Ignore a pop on an empty tracker
  assign pop  = pop_i & ~track_empty_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      track_mem[wr_ptr_q] <= '{id: mgr_req_id_i, we: mgr_req_we_i};
    end
  end

  // Pointers wrap at the tracker depth
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Push and pop together leave the count unchanged
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (push && !pop) begin
      count_q <= count_q + 1'b1;
    end else if (pop && !push) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign head_o        = track_mem[rd_ptr_q];
  assign track_empty_o = (count_q == '0);

endmodule

`default_nettype wire

/* guard_regs.sv */
// Guard configuration registers

`default_nettype none

`include "guard_params.svh"

module guard_regs (
  input  wire                         clk_i,
  input  wire                         reset_i,
  // Register access port
  input  wire                         reg_valid_i,
  input  wire                         reg_write_i,
  input  wire guard_pkg::guard_reg_e  reg_addr_i,
  input  wire [`GUARD_DATA_W-1:0]     reg_wdata_i,
  output logic [`GUARD_DATA_W-1:0]    reg_rdata_o,
  // One-cycle fault pulse from the monitor
  input  wire                         fault_i,
  output logic [`GUARD_CNT_W-1:0]     req_budget_o,
  output logic [`GUARD_CNT_W-1:0]     rsp_budget_o,
  output logic                        irq_o
);

  import guard_pkg::*;

  localparam int FCNT_W = 8;

  logic [`GUARD_CNT_W-1:0] req_budget_q;
  logic [`GUARD_CNT_W-1:0] rsp_budget_q;
  logic                    irq_q;
  logic [FCNT_W-1:0]       fault_cnt_q;
  logic                    wr_en;
  logic                    rd_en;
  logic                    irq_clr;

  assign wr_en = reg_valid_i & reg_write_i;
  assign rd_en = reg_valid_i & ~reg_write_i;
  // Write one to bit 0 clears the pending interrupt
  assign irq_clr = wr_en & (reg_addr_i == IRQ_STATUS) & reg_wdata_i[0];

  // Budgets, reset to the largest value
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_budget_q <= '1;
      rsp_budget_q <= '1;
    end else if (wr_en) begin
      if (reg_addr_i == REQ_BUDGET) begin
        req_budget_q <= reg_wdata_i[`GUARD_CNT_W-1:0];
      end
      if (reg_addr_i == RSP_BUDGET) begin
        rsp_budget_q <= reg_wdata_i[`GUARD_CNT_W-1:0];
      end
    end
  end

  // Sticky irq, a new fault beats a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_q <= 1'b0;
    end else if (fault_i) begin
      irq_q <= 1'b1;
    end else if (irq_clr) begin
      irq_q <= 1'b0;
    end
  end

  // Fault counter, stops at all ones
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fault_cnt_q <= '0;
    end else if (fault_i && (fault_cnt_q != '1)) begin
      fault_cnt_q <= fault_cnt_q + 1'b1;
    end
  end

  // Read data one cycle after the request
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      case (reg_addr_i)
        REQ_BUDGET:  reg_rdata_o <= `GUARD_DATA_W'(req_budget_q);
        RSP_BUDGET:  reg_rdata_o <= `GUARD_DATA_W'(rsp_budget_q);
        IRQ_STATUS:  reg_rdata_o <= `GUARD_DATA_W'(irq_q);
        FAULT_COUNT: reg_rdata_o <= `GUARD_DATA_W'(fault_cnt_q);
        default:     reg_rdata_o <= '0;
      endcase
    end
  end

  assign req_budget_o = req_budget_q;
  assign rsp_budget_o = rsp_budget_q;
  assign irq_o        = irq_q;

endmodule

`default_nettype wire

/* guard_bus_if.sv */
// Request and response channel bundle

`default_nettype none

`include "guard_params.svh"

interface guard_bus_if;

  // Request channel, manager to subordinate
  logic                     req_valid;
  logic                     req_ready;
  logic [`GUARD_ADDR_W-1:0] req_addr;
  // High for a write, low for a read
  logic                     req_we;
  logic [`GUARD_DATA_W-1:0] req_wdata;
  logic [`GUARD_ID_W-1:0]   req_id;

  // Response channel, subordinate to manager
  logic                     rsp_valid;
  logic                     rsp_ready;
  logic [`GUARD_ID_W-1:0]   rsp_id;
  logic [`GUARD_DATA_W-1:0] rsp_rdata;
  logic                     rsp_err;

  // Manager side drives the request
  modport mgr (
    output req_valid, req_addr, req_we, req_wdata, req_id,
    input  req_ready,
    input  rsp_valid, rsp_id, rsp_rdata, rsp_err,
    output rsp_ready
  );

  // Subordinate side drives the response
  modport sub (
    input  req_valid, req_addr, req_we, req_wdata, req_id,
    output req_ready,
    output rsp_valid, rsp_id, rsp_rdata, rsp_err,
    input  rsp_ready
  );

endinterface

`default_nettype wire

/* guard_pkg.sv */
// Subordinate guard types

`default_nettype none

`include "guard_params.svh"

package guard_pkg;

  // Guard FSM states
  typedef enum logic [1:0] {
    // Traffic passes through
    IDLE        = 2'd0,
    // Answer all tracked IDs with errors
    FAULT_DRAIN = 2'd1,
    // Hold reset request until the subordinate is back
    RESET_WAIT  = 2'd2
  } guard_state_e;

  // Register map of the configuration port
  typedef enum logic [1:0] {
    REQ_BUDGET  = 2'd0,
    RSP_BUDGET  = 2'd1,
    IRQ_STATUS  = 2'd2,
    FAULT_COUNT = 2'd3
  } guard_reg_e;

  // One outstanding transaction
  typedef struct packed {
    logic [`GUARD_ID_W-1:0] id;
    // Set when the response is a write acknowledgement
    logic                   we;
  } track_entry_t;

endpackage

`default_nettype wire

/* guard_params.svh */
// Subordinate guard sizes

`ifndef GUARD_PARAMS_SVH
`define GUARD_PARAMS_SVH

// Request address width
`define GUARD_ADDR_W 16

// Read and write data width, also the register port width
`define GUARD_DATA_W 32

// Transaction ID width
`define GUARD_ID_W 4

// Budget and latency counter width
`define GUARD_CNT_W 8

// Depth of the in-flight tracker
`define GUARD_MAX_TXNS 4

`endif
